// ==== design/rv32_isa_pkg.sv ====
package rv32_isa_pkg;

   // major opcodes, bits [6:0]
   localparam logic [6:0] opcode_lui      = 7'b0110111;
   localparam logic [6:0] opcode_auipc    = 7'b0010111;
   localparam logic [6:0] opcode_jal      = 7'b1101111;
   localparam logic [6:0] opcode_jalr     = 7'b1100111;
   localparam logic [6:0] opcode_branch   = 7'b1100011;
   localparam logic [6:0] opcode_load     = 7'b0000011;
   localparam logic [6:0] opcode_store    = 7'b0100011;
   localparam logic [6:0] opcode_op_imm   = 7'b0010011;
   localparam logic [6:0] opcode_op       = 7'b0110011;
   localparam logic [6:0] opcode_misc_mem = 7'b0001111;
   localparam logic [6:0] opcode_system   = 7'b1110011;

   localparam logic [6:0] funct7_base   = 7'b0000000;
   localparam logic [6:0] funct7_alt    = 7'b0100000;  // sub, sra, srai
   localparam logic [6:0] funct7_muldiv = 7'b0000001;

   // integer alu, shared by op and op_imm
   localparam logic [2:0] funct3_add  = 3'b000;
   localparam logic [2:0] funct3_sll  = 3'b001;
   localparam logic [2:0] funct3_slt  = 3'b010;
   localparam logic [2:0] funct3_sltu = 3'b011;
   localparam logic [2:0] funct3_xor  = 3'b100;
   localparam logic [2:0] funct3_srl  = 3'b101;
   localparam logic [2:0] funct3_or   = 3'b110;
   localparam logic [2:0] funct3_and  = 3'b111;

   // m extension
   localparam logic [2:0] funct3_mul    = 3'b000;
   localparam logic [2:0] funct3_mulh   = 3'b001;
   localparam logic [2:0] funct3_mulhsu = 3'b010;
   localparam logic [2:0] funct3_mulhu  = 3'b011;
   localparam logic [2:0] funct3_div    = 3'b100;
   localparam logic [2:0] funct3_divu   = 3'b101;
   localparam logic [2:0] funct3_rem    = 3'b110;
   localparam logic [2:0] funct3_remu   = 3'b111;

   localparam logic [2:0] funct3_beq  = 3'b000;
   localparam logic [2:0] funct3_bne  = 3'b001;
   localparam logic [2:0] funct3_blt  = 3'b100;
   localparam logic [2:0] funct3_bge  = 3'b101;
   localparam logic [2:0] funct3_bltu = 3'b110;
   localparam logic [2:0] funct3_bgeu = 3'b111;

   // system imm12 selects the call
   localparam logic [11:0] imm12_scall  = 12'h000;
   localparam logic [11:0] imm12_sbreak = 12'h001;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } r_view_t;

   typedef struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } i_view_t;

   typedef union packed {
      r_view_t r;
      i_view_t i;
   } rv32_instr_u;

   // six ascii chars, left aligned, space padded
   typedef logic [6*8-1:0] mnemonic_t;

endpackage

// ==== design/trace_pkg.sv ====
package trace_pkg;

   localparam int num_ports = 2;
   localparam int buf_depth = 16;

   typedef logic [$clog2(buf_depth)-1:0] buf_addr_t;
   typedef logic [$clog2(num_ports)-1:0] port_idx_t;

   // saturates at 255
   typedef logic [7:0] drop_cnt_t;

   typedef struct packed {
      port_idx_t                 port_id;
      rv32_isa_pkg::rv32_instr_u instr;
      rv32_isa_pkg::mnemonic_t   mnemonic;
   } trace_rec_t;

endpackage

// ==== design/rv32_mnemonic.sv ====
`timescale 1ns/1ns

module rv32_mnemonic (
   input  rv32_isa_pkg::rv32_instr_u instr,
   output rv32_isa_pkg::mnemonic_t   mnemonic
);

   always_comb begin
      mnemonic = "UNDEF ";
      case (instr.r.opcode)
         rv32_isa_pkg::opcode_lui:   mnemonic = "LUI   ";
         rv32_isa_pkg::opcode_auipc: mnemonic = "AUIPC ";
         rv32_isa_pkg::opcode_jal:   mnemonic = "JAL   ";
         rv32_isa_pkg::opcode_jalr: begin
            if (instr.i.funct3 == 3'b000) mnemonic = "JALR  ";
         end
         rv32_isa_pkg::opcode_branch: begin
            case (instr.r.funct3)
               rv32_isa_pkg::funct3_beq:  mnemonic = "BEQ   ";
               rv32_isa_pkg::funct3_bne:  mnemonic = "BNE   ";
               rv32_isa_pkg::funct3_blt:  mnemonic = "BLT   ";
               rv32_isa_pkg::funct3_bge:  mnemonic = "BGE   ";
               rv32_isa_pkg::funct3_bltu: mnemonic = "BLTU  ";
               rv32_isa_pkg::funct3_bgeu: mnemonic = "BGEU  ";
               default: ;
            endcase
         end
         rv32_isa_pkg::opcode_load: begin
            case (instr.i.funct3)
               3'b000:  mnemonic = "LB    ";
               3'b001:  mnemonic = "LH    ";
               3'b010:  mnemonic = "LW    ";
               3'b100:  mnemonic = "LBU   ";
               3'b101:  mnemonic = "LHU   ";
               default: ;  // ld and lwu are rv64 only
            endcase
         end
         rv32_isa_pkg::opcode_store: begin
            case (instr.r.funct3)
               3'b000:  mnemonic = "SB    ";
               3'b001:  mnemonic = "SH    ";
               3'b010:  mnemonic = "SW    ";
               default: ;
            endcase
         end
         rv32_isa_pkg::opcode_op_imm: begin
            case (instr.i.funct3)
               rv32_isa_pkg::funct3_add:  mnemonic = "ADDI  ";
               rv32_isa_pkg::funct3_slt:  mnemonic = "SLTI  ";
               rv32_isa_pkg::funct3_sltu: mnemonic = "SLTIU ";
               rv32_isa_pkg::funct3_xor:  mnemonic = "XORI  ";
               rv32_isa_pkg::funct3_or:   mnemonic = "ORI   ";
               rv32_isa_pkg::funct3_and:  mnemonic = "ANDI  ";
               rv32_isa_pkg::funct3_sll: begin
                  if (instr.r.funct7 == rv32_isa_pkg::funct7_base) mnemonic = "SLLI  ";
               end
               rv32_isa_pkg::funct3_srl: begin
                  // shamt sits in rs2, upper imm bits pick logical or arithmetic
                  if (instr.r.funct7 == rv32_isa_pkg::funct7_base) mnemonic = "SRLI  ";
                  else if (instr.r.funct7 == rv32_isa_pkg::funct7_alt) mnemonic = "SRAI  ";
               end
               default: ;
            endcase
         end
         rv32_isa_pkg::opcode_op: begin
            if (instr.r.funct7 == rv32_isa_pkg::funct7_base) begin
               case (instr.r.funct3)
                  rv32_isa_pkg::funct3_add:  mnemonic = "ADD   ";
                  rv32_isa_pkg::funct3_sll:  mnemonic = "SLL   ";
                  rv32_isa_pkg::funct3_slt:  mnemonic = "SLT   ";
                  rv32_isa_pkg::funct3_sltu: mnemonic = "SLTU  ";
                  rv32_isa_pkg::funct3_xor:  mnemonic = "XOR   ";
                  rv32_isa_pkg::funct3_srl:  mnemonic = "SRL   ";
                  rv32_isa_pkg::funct3_or:   mnemonic = "OR    ";
                  rv32_isa_pkg::funct3_and:  mnemonic = "AND   ";
                  default: ;
               endcase
            end else if (instr.r.funct7 == rv32_isa_pkg::funct7_alt) begin
               if (instr.r.funct3 == rv32_isa_pkg::funct3_add) mnemonic = "SUB   ";
               else if (instr.r.funct3 == rv32_isa_pkg::funct3_srl) mnemonic = "SRA   ";
            end else if (instr.r.funct7 == rv32_isa_pkg::funct7_muldiv) begin
               case (instr.r.funct3)
                  rv32_isa_pkg::funct3_mul:    mnemonic = "MUL   ";
                  rv32_isa_pkg::funct3_mulh:   mnemonic = "MULH  ";
                  rv32_isa_pkg::funct3_mulhsu: mnemonic = "MULHSU";
                  rv32_isa_pkg::funct3_mulhu:  mnemonic = "MULHU ";
                  rv32_isa_pkg::funct3_div:    mnemonic = "DIV   ";
                  rv32_isa_pkg::funct3_divu:   mnemonic = "DIVU  ";
                  rv32_isa_pkg::funct3_rem:    mnemonic = "REM   ";
                  rv32_isa_pkg::funct3_remu:   mnemonic = "REMU  ";
                  default: ;
               endcase
            end
         end
         rv32_isa_pkg::opcode_misc_mem: begin
            if (instr.i.funct3 == 3'b000) mnemonic = "FENCE ";
            else if (instr.i.funct3 == 3'b001) mnemonic = "FENCE_";  // fence.i
         end
         rv32_isa_pkg::opcode_system: begin
            if (instr.i.funct3 == 3'b000 && instr.i.rs1 == 5'd0 && instr.i.rd == 5'd0) begin
               if (instr.i.imm12 == rv32_isa_pkg::imm12_scall) mnemonic = "SCALL ";
               else if (instr.i.imm12 == rv32_isa_pkg::imm12_sbreak) mnemonic = "SBREAK";
            end
         end
         default: ;
      endcase
   end

endmodule

// ==== design/trace_port.sv ====
`timescale 1ns/1ns

module trace_port (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      port_id,
   input  logic                      retire_valid,
   input  rv32_isa_pkg::rv32_instr_u retire_instr,
   input  logic                      grant,
   output logic                      pend_valid,
   output trace_pkg::trace_rec_t     pend_rec,
   output trace_pkg::drop_cnt_t      drop_count
);

   rv32_isa_pkg::rv32_instr_u q_mem [2];
   rv32_isa_pkg::rv32_instr_u head;
   rv32_isa_pkg::mnemonic_t   head_mnemonic;
   logic                      rd_ptr;
   logic                      wr_ptr;
   logic [1:0]                count;
   logic                      push;
   logic                      pop;
   logic                      drop;

   assign pend_valid = (count != 2'd0);
   assign pop        = grant & pend_valid;
   // full queue still takes a word when the head leaves this cycle
   assign push       = retire_valid & ((count != 2'd2) | pop);
   assign drop       = retire_valid & ~push;

   assign head = q_mem[rd_ptr];

   rv32_mnemonic u_mnemonic (
      .instr    (head),
      .mnemonic (head_mnemonic)
   );

   assign pend_rec = '{port_id: port_id, instr: head, mnemonic: head_mnemonic};

   always_ff @(posedge clk) begin
      if (push) q_mem[wr_ptr] <= retire_instr;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_ptr <= 1'b0;
         wr_ptr <= 1'b0;
         count  <= 2'd0;
      end else begin
         if (push) wr_ptr <= ~wr_ptr;
         if (pop) rd_ptr <= ~rd_ptr;
         case ({push, pop})
            2'b10:   count <= count + 2'd1;
            2'b01:   count <= count - 2'd1;
            default: ;  // push and pop together keep the level
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         drop_count <= '0;
      end else if (drop && drop_count != '1) begin
         drop_count <= drop_count + 8'd1;
      end
   end

endmodule

// ==== design/trace_arbiter.sv ====
`timescale 1ns/1ns

module trace_arbiter (
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic [trace_pkg::num_ports-1:0]      pend_valid,
   input  trace_pkg::trace_rec_t                pend_rec [trace_pkg::num_ports],
   output logic [trace_pkg::num_ports-1:0]      grant,
   output logic                                 wr_en,
   output trace_pkg::trace_rec_t                wr_rec
);

   trace_pkg::port_idx_t last_winner;
   trace_pkg::port_idx_t sel;

   assign wr_en = |pend_valid;

   always_comb begin
      // contention goes to whoever lost last time
      if (pend_valid[0] && pend_valid[1]) sel = ~last_winner;
      else sel = pend_valid[1];
      grant = '0;
      if (wr_en) grant[sel] = 1'b1;
   end

   assign wr_rec = pend_rec[sel];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         last_winner <= 1'b1;  // port 0 first
      end else if (wr_en) begin
         last_winner <= sel;
      end
   end

endmodule

// ==== design/trace_buffer.sv ====
`timescale 1ns/1ns

module trace_buffer (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  wr_en,
   input  trace_pkg::trace_rec_t wr_rec,
   input  trace_pkg::buf_addr_t  rd_addr,
   output trace_pkg::trace_rec_t rd_data,
   output logic [15:0]           wr_count
);

   trace_pkg::trace_rec_t mem [trace_pkg::buf_depth];
   trace_pkg::buf_addr_t  wr_addr;

   // oldest record is overwritten once the count passes the depth
   assign wr_addr = wr_count[$bits(trace_pkg::buf_addr_t)-1:0];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_count <= 16'd0;
      end else if (wr_en) begin
         wr_count <= wr_count + 16'd1;  // wraps
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) mem[wr_addr] <= wr_rec;
      rd_data <= mem[rd_addr];
   end

endmodule

// ==== design/rv32_trace.sv ====
`timescale 1ns/1ns

module rv32_trace (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic [trace_pkg::num_ports-1:0]   retire_valid,
   input  rv32_isa_pkg::rv32_instr_u         retire_instr [trace_pkg::num_ports],
   input  trace_pkg::buf_addr_t              rd_addr,
   output trace_pkg::trace_rec_t             rd_data,
   output logic [15:0]                       wr_count,
   output trace_pkg::drop_cnt_t              drop_count [trace_pkg::num_ports]
);

   logic [trace_pkg::num_ports-1:0] pend_valid;
   trace_pkg::trace_rec_t           pend_rec [trace_pkg::num_ports];
   logic [trace_pkg::num_ports-1:0] grant;
   logic                            wr_en;
   trace_pkg::trace_rec_t           wr_rec;

   trace_port u_port0 (
      .clk          (clk),
      .rst_n        (rst_n),
      .port_id      (1'b0),
      .retire_valid (retire_valid[0]),
      .retire_instr (retire_instr[0]),
      .grant        (grant[0]),
      .pend_valid   (pend_valid[0]),
      .pend_rec     (pend_rec[0]),
      .drop_count   (drop_count[0])
   );

   trace_port u_port1 (
      .clk          (clk),
      .rst_n        (rst_n),
      .port_id      (1'b1),
      .retire_valid (retire_valid[1]),
      .retire_instr (retire_instr[1]),
      .grant        (grant[1]),
      .pend_valid   (pend_valid[1]),
      .pend_rec     (pend_rec[1]),
      .drop_count   (drop_count[1])
   );

   trace_arbiter u_arbiter (
      .clk        (clk),
      .rst_n      (rst_n),
      .pend_valid (pend_valid),
      .pend_rec   (pend_rec),
      .grant      (grant),
      .wr_en      (wr_en),
      .wr_rec     (wr_rec)
   );

   trace_buffer u_buffer (
      .clk      (clk),
      .rst_n    (rst_n),
      .wr_en    (wr_en),
      .wr_rec   (wr_rec),
      .rd_addr  (rd_addr),
      .rd_data  (rd_data),
      .wr_count (wr_count)
   );

endmodule

// ==== verif/rv32_trace_tb.sv ====
`timescale 1ns/1ns

module rv32_trace_tb;

   localparam int num_cov     = 11 * 8 * 3 + 4;
   localparam int stim_cycles = 8 + num_cov * 3 + 12 * 3 + 12 * 2 + 40 + 20 + 16 * 2;
   localparam int cycle_limit = stim_cycles + 64;

   localparam logic [6:0] opc_tbl [11] = '{
      rv32_isa_pkg::opcode_lui, rv32_isa_pkg::opcode_auipc, rv32_isa_pkg::opcode_jal,
      rv32_isa_pkg::opcode_jalr, rv32_isa_pkg::opcode_branch, rv32_isa_pkg::opcode_load,
      rv32_isa_pkg::opcode_store, rv32_isa_pkg::opcode_op_imm, rv32_isa_pkg::opcode_op,
      rv32_isa_pkg::opcode_misc_mem, rv32_isa_pkg::opcode_system};
   localparam logic [6:0] f7_tbl [3] = '{7'h00, 7'h20, 7'h01};

   // names indexed by funct3 from the rv32im base tables
   localparam rv32_isa_pkg::mnemonic_t branch_names [8] = '{"BEQ   ", "BNE   ", "UNDEF ",
      "UNDEF ", "BLT   ", "BGE   ", "BLTU  ", "BGEU  "};
   localparam rv32_isa_pkg::mnemonic_t load_names [8] = '{"LB    ", "LH    ", "LW    ",
      "UNDEF ", "LBU   ", "LHU   ", "UNDEF ", "UNDEF "};
   localparam rv32_isa_pkg::mnemonic_t store_names [8] = '{"SB    ", "SH    ", "SW    ",
      "UNDEF ", "UNDEF ", "UNDEF ", "UNDEF ", "UNDEF "};
   localparam rv32_isa_pkg::mnemonic_t imm_names [8] = '{"ADDI  ", "SLLI  ", "SLTI  ",
      "SLTIU ", "XORI  ", "SRLI  ", "ORI   ", "ANDI  "};
   localparam rv32_isa_pkg::mnemonic_t op_names [8] = '{"ADD   ", "SLL   ", "SLT   ",
      "SLTU  ", "XOR   ", "SRL   ", "OR    ", "AND   "};
   localparam rv32_isa_pkg::mnemonic_t mul_names [8] = '{"MUL   ", "MULH  ", "MULHSU",
      "MULHU ", "DIV   ", "DIVU  ", "REM   ", "REMU  "};

   logic                      clk;
   logic                      rst_n;
   logic [1:0]                retire_valid;
   rv32_isa_pkg::rv32_instr_u retire_instr [2];
   trace_pkg::buf_addr_t      rd_addr;
   trace_pkg::trace_rec_t     rd_data;
   logic [15:0]               wr_count;
   trace_pkg::drop_cnt_t      drop_count [2];

   integer                seed = 30;
   string                 test_name = "reset state";
   bit                    allow_skip;
   bit                    rd_pending;
   bit                    sweep_req;
   logic [15:0]           seen_count;
   int                    issued;
   int                    base_wr;
   int                    rec_cnt [2];
   int                    base_rec [2];
   int                    base_drop [2];
   logic [31:0]           exp_q0 [$];
   logic [31:0]           exp_q1 [$];
   trace_pkg::trace_rec_t hist [trace_pkg::buf_depth];  // expected record per address

   rv32_trace u_dut (
      .clk          (clk),
      .rst_n        (rst_n),
      .retire_valid (retire_valid),
      .retire_instr (retire_instr),
      .rd_addr      (rd_addr),
      .rd_data      (rd_data),
      .wr_count     (wr_count),
      .drop_count   (drop_count)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("Errors found");
      $fatal(1);
   endtask

   function automatic rv32_isa_pkg::mnemonic_t ref_mnemonic(input logic [31:0] w);
      logic [2:0] f3;
      logic [6:0] f7;
      f3 = w[14:12];
      f7 = w[31:25];
      ref_mnemonic = "UNDEF ";
      case (w[6:0])
         rv32_isa_pkg::opcode_lui:    ref_mnemonic = "LUI   ";
         rv32_isa_pkg::opcode_auipc:  ref_mnemonic = "AUIPC ";
         rv32_isa_pkg::opcode_jal:    ref_mnemonic = "JAL   ";
         rv32_isa_pkg::opcode_jalr:   if (f3 == 3'd0) ref_mnemonic = "JALR  ";
         rv32_isa_pkg::opcode_branch: ref_mnemonic = branch_names[f3];
         rv32_isa_pkg::opcode_load:   ref_mnemonic = load_names[f3];
         rv32_isa_pkg::opcode_store:  ref_mnemonic = store_names[f3];
         rv32_isa_pkg::opcode_op_imm: begin
            ref_mnemonic = imm_names[f3];
            // shifts carry funct7 in the upper immediate
            if (f3 == 3'd1 && f7 != 7'h00) ref_mnemonic = "UNDEF ";
            if (f3 == 3'd5 && f7 == 7'h20) ref_mnemonic = "SRAI  ";
            else if (f3 == 3'd5 && f7 != 7'h00) ref_mnemonic = "UNDEF ";
         end
         rv32_isa_pkg::opcode_op: begin
            if (f7 == 7'h00) ref_mnemonic = op_names[f3];
            else if (f7 == 7'h01) ref_mnemonic = mul_names[f3];
            else if (f7 == 7'h20 && f3 == 3'd0) ref_mnemonic = "SUB   ";
            else if (f7 == 7'h20 && f3 == 3'd5) ref_mnemonic = "SRA   ";
         end
         rv32_isa_pkg::opcode_misc_mem: begin
            if (f3 == 3'd0) ref_mnemonic = "FENCE ";
            else if (f3 == 3'd1) ref_mnemonic = "FENCE_";
         end
         rv32_isa_pkg::opcode_system: begin
            if (w[31:7] == 25'h0) ref_mnemonic = "SCALL ";
            else if (w[31:7] == 25'h2000) ref_mnemonic = "SBREAK";  // imm12 of 1
         end
         default: ;
      endcase
   endfunction

   function automatic logic [31:0] rand_word();
      logic [31:0] r;
      logic [31:0] w;
      r = $random(seed);
      w = $random(seed);
      w[6:0] = opc_tbl[r[7:0] % 8'd11];
      if (r[9:8] != 2'd3) w[31:25] = f7_tbl[r[9:8]];
      if (w[6:0] == rv32_isa_pkg::opcode_system) w[31:7] = {11'd0, r[10], 13'd0};
      if (r[15:12] == 4'd0) w = r;  // raw word now and then
      return w;
   endfunction

   task automatic drive_cycle(input logic [1:0] v, input logic [31:0] w0, input logic [31:0] w1);
      @(posedge clk);
      #1;
      retire_valid    = v;
      retire_instr[0] = w0;
      retire_instr[1] = w1;
      if (v[0]) exp_q0.push_back(w0);
      if (v[1]) exp_q1.push_back(w1);
      issued += int'(v[0]) + int'(v[1]);
   endtask

   task automatic spaced_retire(input bit port, input logic [31:0] w);
      drive_cycle({port, !port}, w, w);
      drive_cycle(2'b00, '0, '0);
      drive_cycle(2'b00, '0, '0);
   endtask

   // every issued word is either written and checked or dropped
   task automatic drain();
      drive_cycle(2'b00, '0, '0);
      @(negedge clk);
      while (int'(wr_count) + int'(drop_count[0]) + int'(drop_count[1]) != issued ||
             rd_pending || seen_count != wr_count) @(negedge clk);
   endtask

   task automatic start_test(input string name, input bit skip);
      test_name  = name;
      allow_skip = skip;
      base_wr    = int'(wr_count);
      for (int p = 0; p < 2; p++) begin
         base_rec[p]  = rec_cnt[p];
         base_drop[p] = int'(drop_count[p]);
      end
      exp_q0.delete();  // dropped words from overload stay behind
      exp_q1.delete();
   endtask

   task automatic take_issued(input logic port, input logic [31:0] got, output bit found,
                              output logic [31:0] want);
      found = 1'b0;
      want  = '0;
      while (!found && (port ? exp_q1.size() : exp_q0.size()) != 0) begin
         if (port) want = exp_q1.pop_front();
         else want = exp_q0.pop_front();
         found = !allow_skip || want == got;
      end
   endtask

   initial begin : record_check
      trace_pkg::trace_rec_t rec;
      trace_pkg::trace_rec_t want_rec;
      logic [31:0]           want;
      bit                    found;
      rd_addr    = '0;
      rd_pending = 1'b0;
      seen_count = '0;
      @(posedge rst_n);
      forever begin
         @(posedge clk);
         #1;
         if (rd_pending) begin  // rd_data now holds the newest address
            rec = rd_data;
            take_issued(rec.port_id, rec.instr, found, want);
            assert (found) else report_failure($sformatf(
               "%s: port %0d wrote word %h that was never issued",
               test_name, rec.port_id, rec.instr));
            want_rec.port_id  = rec.port_id;
            want_rec.instr    = want;
            want_rec.mnemonic = ref_mnemonic(want);
            assert (rec.instr == want) else report_failure($sformatf(
               "mismatch %s instr: expected %h, actual %h", test_name, want, rec.instr));
            assert (rec.mnemonic == want_rec.mnemonic) else report_failure($sformatf(
               "mismatch %s mnemonic of %h: expected %s, actual %s", test_name, want,
               want_rec.mnemonic, rec.mnemonic));
            hist[rd_addr] = want_rec;
            rec_cnt[rec.port_id]++;
            rd_pending = 1'b0;
         end
         if (wr_count != seen_count) begin
            assert (wr_count == seen_count + 16'd1)
               else report_failure("buffer wrote twice in one cycle");
            rd_addr    = seen_count[3:0];
            seen_count = wr_count;
            rd_pending = 1'b1;
         end else if (sweep_req) begin
            for (int a = 0; a < 16; a++) begin
               rd_addr = a[3:0];
               @(posedge clk);
               #1;
               assert (rd_data == hist[a]) else report_failure($sformatf(
                  "mismatch %s addr %0d: expected %h, actual %h", test_name, a, hist[a], rd_data));
            end
            sweep_req = 1'b0;
         end
      end
   end

   initial begin : timeout
      int cycles;
      cycles = 0;
      forever begin
         @(posedge clk);
         cycles++;
         if (cycles > cycle_limit)
            report_failure($sformatf("run exceeded %0d cycles", cycle_limit));
      end
   end

   initial begin : stimulus
      rst_n           = 1'b0;
      retire_valid    = '0;
      retire_instr[0] = '0;
      retire_instr[1] = '0;
      allow_skip      = 1'b0;
      sweep_req       = 1'b0;
      issued          = 0;
      rec_cnt[0]      = 0;
      rec_cnt[1]      = 0;
      repeat (8) @(posedge clk);
      #1;
      rst_n = 1'b1;

      @(negedge clk);
      assert (wr_count == 16'd0 && drop_count[0] == '0 && drop_count[1] == '0)
         else report_failure($sformatf("mismatch %s: expected 0 0 0, actual %0d %0d %0d",
                                       test_name, wr_count, drop_count[0], drop_count[1]));

      start_test("mnemonic coverage", 1'b0);
      for (int o = 0; o < 11; o++)
         for (int f3 = 0; f3 < 8; f3++)
            for (int k = 0; k < 3; k++)
               spaced_retire(1'b0, {f7_tbl[k], 10'd0, f3[2:0], 5'd0, opc_tbl[o]});
      spaced_retire(1'b0, {12'h001, 13'd0, rv32_isa_pkg::opcode_system});
      spaced_retire(1'b0, {12'h000, 5'd3, 8'd0, rv32_isa_pkg::opcode_system});
      spaced_retire(1'b0, 32'hffff_ffff);
      spaced_retire(1'b0, 32'h0000_0000);
      drain();
      assert (rec_cnt[0] - base_rec[0] == num_cov && rec_cnt[1] == base_rec[1])
         else report_failure($sformatf("mismatch %s records: expected %0d/0, actual %0d/%0d",
                             test_name, num_cov, rec_cnt[0] - base_rec[0],
                             rec_cnt[1] - base_rec[1]));

      start_test("single-port flow", 1'b0);
      repeat (12) spaced_retire(1'b1, rand_word());
      drain();
      assert (int'(wr_count) - base_wr == 12 && int'(drop_count[1]) == base_drop[1])
         else report_failure($sformatf("mismatch %s: expected 12 writes 0 drops, actual %0d %0d",
                             test_name, int'(wr_count) - base_wr,
                             int'(drop_count[1]) - base_drop[1]));

      start_test("arbitration fairness", 1'b0);
      repeat (12) begin
         drive_cycle(2'b11, rand_word(), rand_word());
         drive_cycle(2'b00, '0, '0);
      end
      drain();
      for (int p = 0; p < 2; p++) begin
         assert (rec_cnt[p] - base_rec[p] == 12 && int'(drop_count[p]) == base_drop[p])
            else report_failure($sformatf("mismatch %s port %0d: expected 12 0, actual %0d %0d",
                                test_name, p, rec_cnt[p] - base_rec[p],
                                int'(drop_count[p]) - base_drop[p]));
      end

      start_test("overload accounting", 1'b1);
      repeat (40) drive_cycle(2'b11, rand_word(), rand_word());
      drain();
      for (int p = 0; p < 2; p++) begin
         assert (rec_cnt[p] - base_rec[p] + int'(drop_count[p]) - base_drop[p] == 40)
            else report_failure($sformatf("mismatch %s port %0d: expected 40, actual %0d",
                                test_name, p,
                                rec_cnt[p] - base_rec[p] + int'(drop_count[p]) - base_drop[p]));
      end

      start_test("wraparound", 1'b0);
      repeat (20) drive_cycle(2'b01, rand_word(), '0);
      drain();
      assert (int'(wr_count) - base_wr == 20 && int'(drop_count[0]) == base_drop[0])
         else report_failure($sformatf("mismatch %s: expected 20 writes, actual %0d",
                             test_name, int'(wr_count) - base_wr));
      sweep_req = 1'b1;
      wait (!sweep_req);

      $display("No errors");
      $finish;
   end

endmodule

// ==== rv32_trace.f ====
design/rv32_isa_pkg.sv
design/trace_pkg.sv
design/rv32_mnemonic.sv
design/trace_port.sv
design/trace_arbiter.sv
design/trace_buffer.sv
design/rv32_trace.sv
verif/rv32_trace_tb.sv

// ==== Makefile ====
# Verilator build and run for the rv32_trace testbench
# override any variable on the command line, e.g. make LOG=run.log

VERILATOR  ?= verilator
TOP        ?= rv32_trace_tb
RTL_TOP    ?= rv32_trace
FILELIST   ?= rv32_trace.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG   ?= No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
